//--- bench/tagdir_tb.sv
/*
 * Testbench for the tag directory
 * Clock, reset, Wishbone master stimulus, reference directory model,
 * directed and random tests, ack timing checks and the closing summary
 */
module tagdir_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import tagdir_pkg::*;

	localparam int LINE_ADDR_WIDTH = 16;
	localparam int SET_INDEX_WIDTH = 4;
	localparam int RANDOM_REQUESTS = 400;
	// Reset loads, directed requests and the random run
	localparam int TOTAL_REQUESTS = 16 + 12 + RANDOM_REQUESTS;
	// A request takes at most eight cycles including the idle gap
	localparam int CYCLE_LIMIT = 8 * TOTAL_REQUESTS + 16;

	logic clk;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [LINE_ADDR_WIDTH-1:0] adr;
	wb_word_t dat_i;
	wb_word_t dat_o;
	logic ack;

	// Reference directory, indexed by set and way
	logic [11:0] m_tag [16][4];
	logic m_valid [16][4];
	logic m_dirty [16][4];

	// Small address pool so that ways conflict and hits are frequent
	logic [3:0] pool_set [3];
	logic [11:0] pool_tag [6];

	int errors;
	int timing_errors;
	int tests_run;
	int tests_passed;
	int test_start;
	int requests_done;
	int cycle_count;
	int held_way;
	wb_word_t result;
	logic [15:0] addr_a;
	logic [15:0] addr_b;
	logic [15:0] rand_addr;
	op_t rand_op;
	way_t rand_way;
	logic rand_we;

	tagdir_top #(
		.LINE_ADDR_WIDTH(LINE_ADDR_WIDTH),
		.SET_INDEX_WIDTH(SET_INDEX_WIDTH)
	) dut0 (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Watchdog that ends a run whose ack has stopped coming
	initial
	begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, ack never came for request %0d",
			cycle_count, requests_done);
		$display("Simulation failed");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s expected %h actual %h at %0t", name, expected, actual, $time);
			errors++;
		end
	endtask

	// Way of the model that holds the address, or -1 when the line is absent
	function automatic int model_hit_way(input logic [15:0] addr);
		int found;
		found = -1;
		for (int w = 0; w < 4; w++)
			if (m_valid[addr[3:0]][w] && m_tag[addr[3:0]][w] == addr[15:4])
				found = w;
		return found;
	endfunction

	// Predicts the result word of one request and applies its update to the model
	task automatic model_request(input logic write, input wb_word_t data,
		input logic [15:0] addr, output wb_word_t expected);
		logic [2:0] op;
		logic [1:0] way;
		logic [1:0] rep_way;
		logic [3:0] set;
		int hit_way;
		op = write ? data[2:0] : op_load;
		// Codes above fill behave as loads
		if (op > op_fill)
			op = op_load;
		way = data[5:4];
		set = addr[3:0];
		hit_way = model_hit_way(addr);
		expected = '0;
		expected[RES_HIT_BIT] = hit_way >= 0;
		if (op == op_fill || hit_way >= 0)
		begin
			rep_way = (op == op_fill) ? way : 2'(hit_way);
			expected[RES_WAY_LSB +: 2] = rep_way;
			// An empty way reports no tag and no dirty bit
			if (m_valid[set][rep_way])
			begin
				expected[RES_VALID_BIT] = 1'b1;
				expected[RES_DIRTY_BIT] = m_dirty[set][rep_way];
				expected[RES_TAG_LSB +: 12] = m_tag[set][rep_way];
			end
		end
		if (op == op_fill)
		begin
			m_tag[set][way] = addr[15:4];
			m_valid[set][way] = 1'b1;
			m_dirty[set][way] = 1'b0;
		end
		else if (hit_way >= 0)
		begin
			if (op == op_store)
				m_dirty[set][hit_way] = 1'b1;
			else if (op == op_flush)
				m_dirty[set][hit_way] = 1'b0;
			else if (op == op_invalidate)
				m_valid[set][hit_way] = 1'b0;
		end
	endtask

	// Request word with the op and fill way in place and noise elsewhere
	function automatic wb_word_t request_word(input op_t op, input way_t way);
		wb_word_t word;
		word = $urandom;
		word[2:0] = op;
		word[5:4] = way;
		return word;
	endfunction

	// One Wishbone transaction, started and ended on a falling edge
	task automatic do_request(input logic write, input wb_word_t data,
		input logic [15:0] addr, output wb_word_t got);
		wb_word_t expected;
		int latency;
		int errors_before;
		model_request(write, data, addr, expected);
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = addr;
		dat_i = data;
		latency = 0;
		// The first rising edge accepts and ack rises on the fourth edge after it
		do
		begin
			@(negedge clk);
			latency++;
		end
		while (ack !== 1'b1);
		got = dat_o;
		errors_before = errors;
		check_value("ack latency", 32'd5, latency);
		timing_errors += errors - errors_before;
		check_value("dat_o", expected, got);
		stb = 1'b0;
		cyc = 1'b0;
		we = 1'b0;
		@(negedge clk);
		errors_before = errors;
		check_value("ack", 32'd0, {31'd0, ack});
		timing_errors += errors - errors_before;
		repeat ($urandom_range(0, 2)) @(negedge clk);
		requests_done++;
	endtask

	task automatic finish_test(input string name, input int new_errors);
		tests_run++;
		if (new_errors == 0)
		begin
			tests_passed++;
			$display("test %0d %s: passed", tests_run, name);
		end
		else
			$display("test %0d %s: %0d errors", tests_run, name, new_errors);
		test_start = errors;
	endtask

	initial
	begin
		void'($urandom(32'he605));
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_i = '0;
		errors = 0;
		timing_errors = 0;
		tests_run = 0;
		tests_passed = 0;
		test_start = 0;
		requests_done = 0;
		for (int s = 0; s < 16; s++)
			for (int w = 0; w < 4; w++)
			begin
				m_tag[s][w] = '0;
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
			end
		// Sets lie apart and the low tag nibble keeps the pool tags distinct
		for (int i = 0; i < 3; i++)
			pool_set[i] = 4'($urandom_range(0, 4) + i * 5);
		for (int i = 0; i < 6; i++)
			pool_tag[i] = {8'($urandom), 4'(i)};
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// An empty directory answers every load with a zero word
		for (int i = 0; i < 16; i++)
		begin
			do_request(1'($urandom), request_word(op_load, way_t'($urandom)),
				16'($urandom), result);
			check_value("dat_o after reset", 32'd0, result);
		end
		finish_test("loads after reset", errors - test_start);

		addr_a = {pool_tag[0], pool_set[0]};
		addr_b = {pool_tag[1], pool_set[0]};
		do_request(1'b1, request_word(op_fill, 2'd2), addr_a, result);
		do_request(1'b1, request_word(op_load, 2'd0), addr_a, result);
		check_value("load hit", 32'd1, result[RES_HIT_BIT]);
		check_value("load way", 32'd2, result[RES_WAY_LSB +: 2]);
		check_value("load dirty", 32'd0, result[RES_DIRTY_BIT]);
		finish_test("fill then load", errors - test_start);

		do_request(1'b1, request_word(op_store, 2'd0), addr_a, result);
		do_request(1'b1, request_word(op_load, 2'd0), addr_a, result);
		check_value("dirty after store", 32'd1, result[RES_DIRTY_BIT]);
		// Evicting the dirty line must hand back its tag for write back
		do_request(1'b1, request_word(op_fill, 2'd2), addr_b, result);
		check_value("victim valid", 32'd1, result[RES_VALID_BIT]);
		check_value("victim dirty", 32'd1, result[RES_DIRTY_BIT]);
		check_value("victim tag", pool_tag[0], result[RES_TAG_LSB +: 16]);
		do_request(1'b1, request_word(op_store, 2'd0), addr_b, result);
		do_request(1'b1, request_word(op_flush, 2'd0), addr_b, result);
		check_value("flush hit", 32'd1, result[RES_HIT_BIT]);
		do_request(1'b1, request_word(op_load, 2'd0), addr_b, result);
		check_value("dirty after flush", 32'd0, result[RES_DIRTY_BIT]);
		finish_test("store, victim and flush", errors - test_start);

		do_request(1'b1, request_word(op_invalidate, 2'd0), addr_b, result);
		check_value("invalidate hit", 32'd1, result[RES_HIT_BIT]);
		do_request(1'b1, request_word(op_load, 2'd0), addr_b, result);
		check_value("hit after invalidate", 32'd0, result[RES_HIT_BIT]);
		do_request(1'b1, request_word(op_store, 2'd0), addr_b, result);
		check_value("dat_o store miss", 32'd0, result);
		do_request(1'b1, request_word(op_load, 2'd0), addr_b, result);
		check_value("dat_o after store miss", 32'd0, result);
		finish_test("invalidate and store miss", errors - test_start);

		// Mixed traffic, including reads and the codes that alias to load
		for (int i = 0; i < RANDOM_REQUESTS; i++)
		begin
			rand_addr = {pool_tag[$urandom_range(0, 5)], pool_set[$urandom_range(0, 2)]};
			rand_op = op_t'($urandom_range(0, 7));
			rand_we = $urandom_range(0, 7) != 0;
			held_way = model_hit_way(rand_addr);
			// A present line is refilled into its own way only
			if (rand_op == op_fill && held_way >= 0)
				rand_way = way_t'(held_way);
			else
				rand_way = way_t'($urandom);
			do_request(rand_we, request_word(rand_op, rand_way), rand_addr, result);
		end
		finish_test("random requests", errors - test_start);
		finish_test("ack timing", timing_errors);

		$display("%0d tests, %0d passed, %0d requests, %0d errors",
			tests_run, tests_passed, requests_done, errors);
		if (errors == 0 && tests_passed == tests_run)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- design/result_port.sv
/*
 * Wishbone result side
 * Packs the directory outcome into the result word and pulses ack
 */
module result_port #(
	parameter int TAG_WIDTH = 12
) (
	input logic clk,
	input logic reset,
	input logic dir_valid,
	input logic dir_hit,
	input tagdir_pkg::way_t dir_way,
	input logic dir_dirty,
	input logic dir_old_valid,
	input logic [TAG_WIDTH-1:0] dir_old_tag,
	output logic ack,
	output tagdir_pkg::wb_word_t dat_o
);
	import tagdir_pkg::*;

	wb_word_t result_word;

	// Unused bits stay zero, the tag is zero extended into the upper half
	always_comb
	begin
		result_word = '0;
		result_word[RES_HIT_BIT] = dir_hit;
		result_word[RES_WAY_LSB +: 2] = dir_way;
		result_word[RES_DIRTY_BIT] = dir_dirty;
		result_word[RES_VALID_BIT] = dir_old_valid;
		result_word[RES_TAG_LSB +: TAG_WIDTH] = dir_old_tag;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			ack <= 1'b0;
		else
			ack <= dir_valid;
	end

	// The word stays on dat_o after ack until the next result
	always_ff @(posedge clk)
	begin
		if (dir_valid)
			dat_o <= result_word;
	end

	// The slave never holds ack, the master sees it for one cycle only
	assert property (@(posedge clk) disable iff (reset) ack |=> !ack);

endmodule

//--- design/tag_dir_stage.sv
/*
 * Directory stage
 * Tag compare and hit way encoding, tag, valid and dirty update
 * generation, and the registered outcome with victim fields for a fill
 */
module tag_dir_stage #(
	parameter int LINE_ADDR_WIDTH = tagdir_pkg::DEFAULT_LINE_ADDR_WIDTH,
	parameter int SET_INDEX_WIDTH = tagdir_pkg::DEFAULT_SET_INDEX_WIDTH
) (
	input logic clk,
	input logic reset,
	input logic lookup_valid,
	input tagdir_pkg::op_t lookup_op,
	input tagdir_pkg::way_t lookup_way,
	input logic [LINE_ADDR_WIDTH-1:0] lookup_addr,
	input logic [LINE_ADDR_WIDTH-SET_INDEX_WIDTH-1:0] tag0,
	input logic [LINE_ADDR_WIDTH-SET_INDEX_WIDTH-1:0] tag1,
	input logic [LINE_ADDR_WIDTH-SET_INDEX_WIDTH-1:0] tag2,
	input logic [LINE_ADDR_WIDTH-SET_INDEX_WIDTH-1:0] tag3,
	input logic valid0,
	input logic valid1,
	input logic valid2,
	input logic valid3,
	input logic dirty0,
	input logic dirty1,
	input logic dirty2,
	input logic dirty3,
	output logic update_tag_enable,
	output tagdir_pkg::way_t update_tag_way,
	output logic update_tag_valid,
	output logic [SET_INDEX_WIDTH-1:0] update_set,
	output logic [LINE_ADDR_WIDTH-SET_INDEX_WIDTH-1:0] update_tag,
	output logic update_dirty0,
	output logic update_dirty1,
	output logic update_dirty2,
	output logic update_dirty3,
	output logic new_dirty,
	output logic dir_valid,
	output logic dir_hit,
	output tagdir_pkg::way_t dir_way,
	output logic dir_dirty,
	output logic dir_old_valid,
	output logic [LINE_ADDR_WIDTH-SET_INDEX_WIDTH-1:0] dir_old_tag
);
	import tagdir_pkg::*;

	localparam int TAG_WIDTH = LINE_ADDR_WIDTH - SET_INDEX_WIDTH;

	logic [TAG_WIDTH-1:0] requested_tag;
	logic [TAG_WIDTH-1:0] way_tag [NUM_WAYS];
	logic [NUM_WAYS-1:0] way_valid;
	logic [NUM_WAYS-1:0] way_dirty;
	logic [NUM_WAYS-1:0] hit;
	logic [NUM_WAYS-1:0] dirty_sel;
	logic cache_hit;
	way_t hit_way;
	way_t report_way;
	logic report_en;
	logic dirty_en;
	logic is_store;
	logic is_flush;
	logic is_invalidate;
	logic is_fill;

	assign requested_tag = lookup_addr[LINE_ADDR_WIDTH-1:SET_INDEX_WIDTH];
	assign way_tag[0] = tag0;
	assign way_tag[1] = tag1;
	assign way_tag[2] = tag2;
	assign way_tag[3] = tag3;
	assign way_valid = {valid3, valid2, valid1, valid0};
	assign way_dirty = {dirty3, dirty2, dirty1, dirty0};

	// Codes above fill fall through as loads, which touch nothing
	assign is_store = lookup_op == op_store;
	assign is_flush = lookup_op == op_flush;
	assign is_invalidate = lookup_op == op_invalidate;
	assign is_fill = lookup_op == op_fill;

	always_comb
	begin
		for (int w = 0; w < NUM_WAYS; w++)
			hit[w] = way_valid[w] && way_tag[w] == requested_tag;
	end

	assign cache_hit = |hit;
	assign hit_way = {hit[2] | hit[3], hit[1] | hit[3]};

	// Fills rewrite the named way, invalidates drop the valid bit of the hit way
	assign update_tag_enable = lookup_valid && (is_fill || (is_invalidate && cache_hit));
	assign update_tag_way = is_invalidate ? hit_way : lookup_way;
	assign update_tag_valid = !is_invalidate;
	assign update_set = lookup_addr[SET_INDEX_WIDTH-1:0];
	assign update_tag = requested_tag;

	// A fill leaves the line clean, store sets dirty and flush clears it
	assign dirty_en = lookup_valid && (is_fill || (cache_hit && (is_store || is_flush)));
	assign new_dirty = is_store;

	always_comb
	begin
		for (int w = 0; w < NUM_WAYS; w++)
			dirty_sel[w] = dirty_en && (is_fill ? lookup_way == way_t'(w) : hit[w]);
	end

	assign update_dirty0 = dirty_sel[0];
	assign update_dirty1 = dirty_sel[1];
	assign update_dirty2 = dirty_sel[2];
	assign update_dirty3 = dirty_sel[3];

	// A fill reports the victim way, anything else the hit way or nothing
	assign report_way = is_fill ? lookup_way : hit_way;
	assign report_en = is_fill || cache_hit;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			dir_valid <= 1'b0;
		else
			dir_valid <= lookup_valid;
	end

	// Tag and dirty of an empty way carry no meaning and are reported as zero
	always_ff @(posedge clk)
	begin
		if (lookup_valid)
		begin
			dir_hit <= cache_hit;
			dir_way <= report_en ? report_way : '0;
			dir_old_valid <= report_en && way_valid[report_way];
			dir_dirty <= report_en && way_valid[report_way] && way_dirty[report_way];
			dir_old_tag <= (report_en && way_valid[report_way]) ? way_tag[report_way] : '0;
		end
	end

	// A tag lives in at most one way of a set
	assert property (@(posedge clk) disable iff (reset) lookup_valid |-> $onehot0(hit));

endmodule

//--- design/tag_store.sv
/*
 * Tag, valid and dirty storage for the four ways
 * Registered read of one set per request and update write ports
 * driven by the directory stage
 */
module tag_store #(
	parameter int LINE_ADDR_WIDTH = tagdir_pkg::DEFAULT_LINE_ADDR_WIDTH,
	parameter int SET_INDEX_WIDTH = tagdir_pkg::DEFAULT_SET_INDEX_WIDTH
) (
	input logic clk,
	input logic reset,
	input logic req_valid,
	input tagdir_pkg::op_t req_op,
	input tagdir_pkg::way_t req_way,
	input logic [LINE_ADDR_WIDTH-1:0] req_addr,
	input logic update_tag_enable,
	input tagdir_pkg::way_t update_tag_way,
	input logic update_tag_valid,
	input logic [SET_INDEX_WIDTH-1:0] update_set,
	input logic [LINE_ADDR_WIDTH-SET_INDEX_WIDTH-1:0] update_tag,
	input logic update_dirty0,
	input logic update_dirty1,
	input logic update_dirty2,
	input logic update_dirty3,
	input logic new_dirty,
	output logic lookup_valid,
	output tagdir_pkg::op_t lookup_op,
	output tagdir_pkg::way_t lookup_way,
	output logic [LINE_ADDR_WIDTH-1:0] lookup_addr,
	output logic [LINE_ADDR_WIDTH-SET_INDEX_WIDTH-1:0] tag0,
	output logic [LINE_ADDR_WIDTH-SET_INDEX_WIDTH-1:0] tag1,
	output logic [LINE_ADDR_WIDTH-SET_INDEX_WIDTH-1:0] tag2,
	output logic [LINE_ADDR_WIDTH-SET_INDEX_WIDTH-1:0] tag3,
	output logic valid0,
	output logic valid1,
	output logic valid2,
	output logic valid3,
	output logic dirty0,
	output logic dirty1,
	output logic dirty2,
	output logic dirty3
);
	import tagdir_pkg::*;

	localparam int TAG_WIDTH = LINE_ADDR_WIDTH - SET_INDEX_WIDTH;
	localparam int NUM_SETS = 1 << SET_INDEX_WIDTH;

	logic [TAG_WIDTH-1:0] tag_mem [NUM_WAYS][NUM_SETS];
	logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_bits;
	logic [NUM_SETS-1:0][NUM_WAYS-1:0] dirty_bits;
	logic [NUM_WAYS-1:0] update_dirty;
	logic [SET_INDEX_WIDTH-1:0] read_set;

	assign update_dirty = {update_dirty3, update_dirty2, update_dirty1, update_dirty0};
	assign read_set = req_addr[SET_INDEX_WIDTH-1:0];

	// An invalidate only drops the valid bit and leaves the stored tag alone
	always_ff @(posedge clk)
	begin
		if (update_tag_enable && update_tag_valid)
			tag_mem[update_tag_way][update_set] <= update_tag;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			valid_bits <= '0;
			dirty_bits <= '0;
			lookup_valid <= 1'b0;
		end
		else
		begin
			lookup_valid <= req_valid;
			if (update_tag_enable)
				valid_bits[update_set][update_tag_way] <= update_tag_valid;
			for (int w = 0; w < NUM_WAYS; w++)
			begin
				if (update_dirty[w])
					dirty_bits[update_set][w] <= new_dirty;
			end
		end
	end

	// Read one whole set and pass the request along beside it
	always_ff @(posedge clk)
	begin
		if (req_valid)
		begin
			lookup_op <= req_op;
			lookup_way <= req_way;
			lookup_addr <= req_addr;
			tag0 <= tag_mem[0][read_set];
			tag1 <= tag_mem[1][read_set];
			tag2 <= tag_mem[2][read_set];
			tag3 <= tag_mem[3][read_set];
			{valid3, valid2, valid1, valid0} <= valid_bits[read_set];
			{dirty3, dirty2, dirty1, dirty0} <= dirty_bits[read_set];
		end
	end

	// The directory stage never marks a line dirty while invalidating it
	assert property (@(posedge clk) disable iff (reset)
		(update_tag_enable && !update_tag_valid) |-> !update_dirty[update_tag_way]);

endmodule

//--- design/tagdir_pkg.sv
/*
 * Shared definitions for the tag directory
 * Operation codes, way and Wishbone word types, default widths
 * and the bit positions of the request and result words
 */
package tagdir_pkg;

	// Operation code carried in the low bits of a write request
	typedef logic [2:0] op_t;

	// Index of one way within a set
	typedef logic [1:0] way_t;

	// Wishbone data word
	typedef logic [31:0] wb_word_t;

	localparam op_t op_load       = 3'd0;
	localparam op_t op_store      = 3'd1;
	localparam op_t op_flush      = 3'd2;
	localparam op_t op_invalidate = 3'd3;
	localparam op_t op_fill       = 3'd4;

	// The hit encoder and the four tag columns are built for exactly four ways
	localparam int NUM_WAYS = 4;

	localparam int DEFAULT_LINE_ADDR_WIDTH = 16;
	localparam int DEFAULT_SET_INDEX_WIDTH = 4;

	// Request word fields
	localparam int REQ_OP_LSB  = 0;
	localparam int REQ_WAY_LSB = 4;

	// Result word fields with the tag zero extended from bit 16 upward
	localparam int RES_HIT_BIT   = 0;
	localparam int RES_WAY_LSB   = 1;
	localparam int RES_DIRTY_BIT = 3;
	localparam int RES_VALID_BIT = 4;
	localparam int RES_TAG_LSB   = 16;

endpackage

//--- design/tagdir_top.sv
/*
 * Tag directory top level
 * Wishbone request port, tag store, directory stage and result port
 */
module tagdir_top #(
	parameter int LINE_ADDR_WIDTH = tagdir_pkg::DEFAULT_LINE_ADDR_WIDTH,
	parameter int SET_INDEX_WIDTH = tagdir_pkg::DEFAULT_SET_INDEX_WIDTH
) (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [LINE_ADDR_WIDTH-1:0] adr,
	input tagdir_pkg::wb_word_t dat_i,
	output tagdir_pkg::wb_word_t dat_o,
	output logic ack
);
	import tagdir_pkg::*;

	localparam int TAG_WIDTH = LINE_ADDR_WIDTH - SET_INDEX_WIDTH;

	// Request port to tag store
	logic req_valid;
	op_t req_op;
	way_t req_way;
	logic [LINE_ADDR_WIDTH-1:0] req_addr;

	// Tag store to directory stage
	logic lookup_valid;
	op_t lookup_op;
	way_t lookup_way;
	logic [LINE_ADDR_WIDTH-1:0] lookup_addr;
	logic [TAG_WIDTH-1:0] tag0, tag1, tag2, tag3;
	logic valid0, valid1, valid2, valid3;
	logic dirty0, dirty1, dirty2, dirty3;

	// Directory stage back to the tag store
	logic update_tag_enable, update_tag_valid, new_dirty;
	way_t update_tag_way;
	logic [SET_INDEX_WIDTH-1:0] update_set;
	logic [TAG_WIDTH-1:0] update_tag;
	logic update_dirty0, update_dirty1, update_dirty2, update_dirty3;

	// Directory stage to result port
	logic dir_valid, dir_hit, dir_dirty, dir_old_valid;
	way_t dir_way;
	logic [TAG_WIDTH-1:0] dir_old_tag;

	wb_request_port #(.LINE_ADDR_WIDTH(LINE_ADDR_WIDTH)) request_port0 (.*);

	tag_store #(
		.LINE_ADDR_WIDTH(LINE_ADDR_WIDTH),
		.SET_INDEX_WIDTH(SET_INDEX_WIDTH)
	) tag_store0 (.*);

	tag_dir_stage #(
		.LINE_ADDR_WIDTH(LINE_ADDR_WIDTH),
		.SET_INDEX_WIDTH(SET_INDEX_WIDTH)
	) dir_stage0 (.*);

	result_port #(.TAG_WIDTH(TAG_WIDTH)) result_port0 (.*);

endmodule

//--- design/wb_request_port.sv
/*
 * Wishbone classic slave request side
 * Accepts one request at a time, decodes op and fill way,
 * and hands a single valid pulse to the tag store
 */
module wb_request_port #(
	parameter int LINE_ADDR_WIDTH = tagdir_pkg::DEFAULT_LINE_ADDR_WIDTH
) (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [LINE_ADDR_WIDTH-1:0] adr,
	input tagdir_pkg::wb_word_t dat_i,
	output logic req_valid,
	output tagdir_pkg::op_t req_op,
	output tagdir_pkg::way_t req_way,
	output logic [LINE_ADDR_WIDTH-1:0] req_addr
);
	import tagdir_pkg::*;

	logic busy;
	logic accept;
	logic captured;

	// Busy stays set from the accept until the master drops stb
	assign accept = cyc && stb && !busy;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			captured <= 1'b0;
			req_valid <= 1'b0;
		end
		else
		begin
			if (accept)
				busy <= 1'b1;
			else if (!stb)
				busy <= 1'b0;

			// The capture cycle holds the decoded fields, the pulse follows it
			captured <= accept;
			req_valid <= captured;
		end
	end

	// A read carries no op in dat_i and is treated as a plain lookup
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			req_op <= we ? op_t'(dat_i[REQ_OP_LSB +: 3]) : op_load;
			req_way <= way_t'(dat_i[REQ_WAY_LSB +: 2]);
			req_addr <= adr;
		end
	end

	// Only one request is in flight, so two pulses can never touch
	assert property (@(posedge clk) disable iff (reset) req_valid |=> !req_valid);

endmodule

//--- list.f
design/tagdir_pkg.sv
design/wb_request_port.sv
design/tag_store.sv
design/tag_dir_stage.sv
design/result_port.sv
design/tagdir_top.sv
bench/tagdir_tb.sv
